// ==== verilog/sata_fis_pkg.sv ====
`default_nettype none

package sata_fis_pkg;

    // host -> device word kind, as written by the AHCI side
    typedef enum logic [1:0] {
        FIS_DATA = 2'd0, // body dword
        FIS_HEAD = 2'd1, // first dword of a FIS
        FIS_LAST = 2'd2  // final dword, frame may start right away
    } h2d_type_t;

    // device -> host word kind, as seen by the host
    typedef enum logic [1:0] {
        D2H_DMA  = 2'd0, // body data
        D2H_HEAD = 2'd1, // first received dword
        D2H_OK   = 2'd2, // status, FIS received fine
        D2H_ERR  = 2'd3  // status, FIS invalidated by link
    } d2h_type_t;

    typedef logic [1:0] fis_mask_t; // word mask, passed through as is

    // 36-bit FIFO entries, kind in the top bits
    typedef struct packed {
        h2d_type_t   kind;
        fis_mask_t   mask;
        logic [31:0] data;
    } h2d_entry_t;

    typedef struct packed {
        d2h_type_t   kind;
        fis_mask_t   mask;
        logic [31:0] data;
    } d2h_entry_t;

    // default sizes
    localparam int DEF_FIFO_ADDR_WIDTH    = 9; // 512 dwords per direction
    localparam int DEF_BITS_TO_START_XMIT = 6; // start xmit at 64 buffered dwords

    // flow flag thresholds
    localparam int H2D_READY_MARGIN = 8;  // host stops when this close to full
    localparam int D2H_BUSY_MARGIN  = 64; // link throttles device this close to full
    localparam int D2H_MANY_LEVEL   = 8;  // burst-worthy amount for the host DMA

endpackage

`default_nettype wire

// ==== verilog/fifo_fill_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_fill_ctrl #(
    parameter int ADDR_WIDTH  = 9,
    parameter int FULL_MARGIN = 8, // almost_full once free words <= margin
    parameter int MANY_LEVEL  = 8  // many once fill >= level
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  wr,        // push one word
    input  wire logic                  rd,        // pop the output word
    output logic      [ADDR_WIDTH-1:0] mem_waddr,
    output logic      [ADDR_WIDTH-1:0] mem_raddr,
    output logic                       mem_re,    // ram -> prefetch latch
    output logic                       out_load,  // prefetch latch -> output reg
    output logic                       out_valid,
    output logic        [ADDR_WIDTH:0] fill,      // written, not yet popped
    output logic                       almost_full,
    output logic                       many
);

    localparam int DEPTH = 1 << ADDR_WIDTH;
    localparam logic [ADDR_WIDTH:0] FULL_LEVEL = (ADDR_WIDTH+1)'(DEPTH);
    localparam logic [ADDR_WIDTH:0] AF_LEVEL   = (ADDR_WIDTH+1)'(DEPTH - FULL_MARGIN);
    localparam logic [ADDR_WIDTH:0] MANY_FILL  = (ADDR_WIDTH+1)'(MANY_LEVEL);

    logic                pre_valid; // ram read latch holds a word
    logic [ADDR_WIDTH:0] mem_cnt;   // words still only in the array

    assign mem_cnt  = fill - (ADDR_WIDTH+1)'(pre_valid) - (ADDR_WIDTH+1)'(out_valid);
    assign out_load = pre_valid && (!out_valid || rd); // output reg free by next edge
    assign mem_re   = (mem_cnt != '0) && (!pre_valid || out_load); // latch free by next edge

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_waddr <= '0;
            mem_raddr <= '0;
            fill      <= '0;
            pre_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (wr)
                mem_waddr <= mem_waddr + 1'b1;
            if (mem_re)
                mem_raddr <= mem_raddr + 1'b1;

            case ({wr, rd})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill; // both or neither
            endcase

            if (mem_re)
                pre_valid <= 1'b1;
            else if (out_load)
                pre_valid <= 1'b0; // moved on, nothing behind it

            if (out_load)
                out_valid <= 1'b1;
            else if (rd)
                out_valid <= 1'b0;
        end
    end

    assign almost_full = (fill >= AF_LEVEL);
    assign many        = (fill >= MANY_FILL);

    // writer must watch its flow flag
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(wr && (fill == FULL_LEVEL)));

    // reader pops only a presented word
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        rd |-> out_valid);

endmodule

`default_nettype wire

// ==== verilog/fifo_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_ram #(
    parameter int  ADDR_WIDTH = 9,
    parameter type entry_t    = logic [35:0]
) (
    input  wire logic                  clk,
    input  wire logic                  we,
    input  wire logic [ADDR_WIDTH-1:0] waddr,
    input  wire entry_t                wdata,
    input  wire logic                  re,       // array read into the latch
    input  wire logic [ADDR_WIDTH-1:0] raddr,
    input  wire logic                  out_load, // latch into the output reg
    output entry_t                     rdata
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    entry_t mem [DEPTH];
    entry_t rd_latch; // synchronous read stage, doubles as prefetch

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
        if (re)
            rd_latch <= mem[raddr];
        if (out_load)
            rdata <= rd_latch; // held until the consumer pops
    end

endmodule

`default_nettype wire

// ==== verilog/h2d_xmit_start_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module h2d_xmit_start_fsm #(
    parameter int BITS_TO_START_XMIT = 6
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   h2d_wr,      // host writes a word
    input  wire sata_fis_pkg::h2d_type_t h2d_wr_type, // kind of that word
    input  wire logic                   start_level, // enough words buffered
    input  wire logic                   frame_busy,  // link cannot take a frame now
    output logic                        frame_req    // one-cycle request to link
);

    import sata_fis_pkg::*;

    typedef enum logic {
        IDLE,
        PENDING // head seen, frame not requested yet
    } state_t;

    state_t state;
    logic   head_wr;
    logic   last_wr;
    logic   go;

    // the level input comes from a fill compare, must be a real threshold
    if (BITS_TO_START_XMIT < 1) begin : g_bad_level
        $error("start level must be at least two words");
    end

    assign head_wr = h2d_wr && (h2d_wr_type == FIS_HEAD);
    assign last_wr = h2d_wr && (h2d_wr_type == FIS_LAST);

    // whole FIS in, or enough of it to keep the link fed
    assign go = (state == PENDING) && !frame_busy && (last_wr || start_level);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            frame_req <= 1'b0;
        end else begin
            frame_req <= go;
            if (head_wr)
                state <= PENDING; // next FIS queued behind this one
            else if (go)
                state <= IDLE;
        end
    end

    // the link sees exactly one request per head
    a_req_pulse: assert property (@(posedge clk) disable iff (rst)
        frame_req |=> !frame_req);

endmodule

`default_nettype wire

// ==== verilog/d2h_fis_tagger.sv ====
`timescale 1ns/1ps
`default_nettype none

module d2h_fis_tagger (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic             [31:0] rx_data,
    input  wire sata_fis_pkg::fis_mask_t rx_mask,
    input  wire logic                    rx_valid,         // no back-pressure
    input  wire logic                    incom_start,      // FIS begins
    input  wire logic                    incom_done,       // FIS received ok
    input  wire logic                    incom_invalidate, // FIS received bad
    output logic                         fifo_wr,
    output sata_fis_pkg::d2h_entry_t     fifo_entry
);

    import sata_fis_pkg::*;

    d2h_type_t cur_tag;   // kind of the next entry
    logic      status_wr; // status entry goes out this cycle
    logic      fis_end;

    assign fis_end = incom_done || incom_invalidate;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_tag   <= D2H_HEAD;
            status_wr <= 1'b0;
        end else begin
            if (incom_start)
                cur_tag <= D2H_HEAD;
            else if (rx_valid)
                cur_tag <= D2H_DMA; // everything after the head
            else if (fis_end)
                cur_tag <= incom_invalidate ? D2H_ERR : D2H_OK;

            // only once per FIS, and only if a word came in
            status_wr <= fis_end && (cur_tag == D2H_DMA);
        end
    end

    assign fifo_wr = rx_valid || status_wr;

    always_comb begin
        fifo_entry.kind = cur_tag;
        if (status_wr) begin
            fifo_entry.mask = '0; // status carries no payload
            fifo_entry.data = '0;
        end else begin
            fifo_entry.mask = rx_mask;
            fifo_entry.data = rx_data;
        end
    end

    // status slot relies on the link leaving a gap after the last word
    a_no_data_at_end: assert property (@(posedge clk) disable iff (rst)
        !(rx_valid && fis_end));

endmodule

`default_nettype wire

// ==== verilog/sata_fis_buffers.sv ====
`timescale 1ns/1ps
`default_nettype none

module sata_fis_buffers #(
    parameter int FIFO_ADDR_WIDTH    = sata_fis_pkg::DEF_FIFO_ADDR_WIDTH,
    parameter int BITS_TO_START_XMIT = sata_fis_pkg::DEF_BITS_TO_START_XMIT
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    // host -> device, from the AHCI side
    input  wire logic             [31:0] h2d_data,
    input  wire sata_fis_pkg::fis_mask_t h2d_mask,
    input  wire sata_fis_pkg::h2d_type_t h2d_type,
    input  wire logic                    h2d_valid,
    output logic                         h2d_ready,
    // device -> host, to the AHCI side
    output logic                  [31:0] d2h_data,
    output sata_fis_pkg::fis_mask_t      d2h_mask,
    output sata_fis_pkg::d2h_type_t      d2h_type,
    output logic                         d2h_valid,
    output logic                         d2h_many,
    input  wire logic                    d2h_ready,
    // link transmit
    output logic                  [31:0] ll_tx_data,
    output sata_fis_pkg::fis_mask_t      ll_tx_mask,
    output logic                         ll_tx_last,
    output logic                         ll_tx_valid,
    input  wire logic                    ll_tx_strobe,
    output logic                         ll_frame_req,
    input  wire logic                    ll_frame_busy,
    // link receive
    input  wire logic             [31:0] ll_rx_data,
    input  wire sata_fis_pkg::fis_mask_t ll_rx_mask,
    input  wire logic                    ll_rx_valid,
    input  wire logic                    ll_incom_start,
    input  wire logic                    ll_incom_done,
    input  wire logic                    ll_incom_invalidate,
    output logic                         ll_rx_busy
);

    import sata_fis_pkg::*;

    localparam int XMIT_START_WORDS = 1 << BITS_TO_START_XMIT;

    // h2d path
    h2d_entry_t                 h2d_wr_entry;
    h2d_entry_t                 h2d_rd_entry;
    logic                       h2d_rd;
    logic [FIFO_ADDR_WIDTH-1:0] h2d_waddr;
    logic [FIFO_ADDR_WIDTH-1:0] h2d_raddr;
    logic                       h2d_mem_re;
    logic                       h2d_out_load;
    logic                       h2d_almost_full;
    logic                       h2d_start_level;

    // d2h path
    d2h_entry_t                 d2h_wr_entry;
    d2h_entry_t                 d2h_rd_entry;
    logic                       d2h_wr;
    logic                       d2h_rd;
    logic [FIFO_ADDR_WIDTH-1:0] d2h_waddr;
    logic [FIFO_ADDR_WIDTH-1:0] d2h_raddr;
    logic                       d2h_mem_re;
    logic                       d2h_out_load;

    assign h2d_wr_entry = '{kind: h2d_type, mask: h2d_mask, data: h2d_data};
    assign h2d_rd       = ll_tx_strobe && ll_tx_valid; // strobe on empty is ignored
    assign h2d_ready    = !h2d_almost_full;

    assign ll_tx_data = h2d_rd_entry.data;
    assign ll_tx_mask = h2d_rd_entry.mask;
    assign ll_tx_last = ll_tx_valid && (h2d_rd_entry.kind == FIS_LAST);

    fifo_fill_ctrl #(
        .ADDR_WIDTH (FIFO_ADDR_WIDTH),
        .FULL_MARGIN(H2D_READY_MARGIN),
        .MANY_LEVEL (XMIT_START_WORDS)   // level that may start the frame
    ) u_h2d_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wr         (h2d_valid),
        .rd         (h2d_rd),
        .mem_waddr  (h2d_waddr),
        .mem_raddr  (h2d_raddr),
        .mem_re     (h2d_mem_re),
        .out_load   (h2d_out_load),
        .out_valid  (ll_tx_valid),
        .fill       (),
        .almost_full(h2d_almost_full),
        .many       (h2d_start_level)
    );

    fifo_ram #(
        .ADDR_WIDTH(FIFO_ADDR_WIDTH),
        .entry_t   (h2d_entry_t)
    ) u_h2d_ram (
        .clk     (clk),
        .we      (h2d_valid),
        .waddr   (h2d_waddr),
        .wdata   (h2d_wr_entry),
        .re      (h2d_mem_re),
        .raddr   (h2d_raddr),
        .out_load(h2d_out_load),
        .rdata   (h2d_rd_entry)
    );

    h2d_xmit_start_fsm #(
        .BITS_TO_START_XMIT(BITS_TO_START_XMIT)
    ) u_xmit_start (
        .clk        (clk),
        .rst        (rst),
        .h2d_wr     (h2d_valid),
        .h2d_wr_type(h2d_type),
        .start_level(h2d_start_level),
        .frame_busy (ll_frame_busy),
        .frame_req  (ll_frame_req)
    );

    d2h_fis_tagger u_tagger (
        .clk             (clk),
        .rst             (rst),
        .rx_data         (ll_rx_data),
        .rx_mask         (ll_rx_mask),
        .rx_valid        (ll_rx_valid),
        .incom_start     (ll_incom_start),
        .incom_done      (ll_incom_done),
        .incom_invalidate(ll_incom_invalidate),
        .fifo_wr         (d2h_wr),
        .fifo_entry      (d2h_wr_entry)
    );

    assign d2h_rd = d2h_valid && d2h_ready;

    fifo_fill_ctrl #(
        .ADDR_WIDTH (FIFO_ADDR_WIDTH),
        .FULL_MARGIN(D2H_BUSY_MARGIN),   // room left for words already in flight
        .MANY_LEVEL (D2H_MANY_LEVEL)
    ) u_d2h_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wr         (d2h_wr),
        .rd         (d2h_rd),
        .mem_waddr  (d2h_waddr),
        .mem_raddr  (d2h_raddr),
        .mem_re     (d2h_mem_re),
        .out_load   (d2h_out_load),
        .out_valid  (d2h_valid),
        .fill       (),
        .almost_full(ll_rx_busy),
        .many       (d2h_many)
    );

    fifo_ram #(
        .ADDR_WIDTH(FIFO_ADDR_WIDTH),
        .entry_t   (d2h_entry_t)
    ) u_d2h_ram (
        .clk     (clk),
        .we      (d2h_wr),
        .waddr   (d2h_waddr),
        .wdata   (d2h_wr_entry),
        .re      (d2h_mem_re),
        .raddr   (d2h_raddr),
        .out_load(d2h_out_load),
        .rdata   (d2h_rd_entry)
    );

    assign d2h_data = d2h_rd_entry.data;
    assign d2h_mask = d2h_rd_entry.mask;
    assign d2h_type = d2h_rd_entry.kind;

endmodule

`default_nettype wire

// ==== tb/tb_sata_fis_buffers.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sata_fis_buffers;

    import sata_fis_pkg::*;

    localparam int DEPTH      = 1 << DEF_FIFO_ADDR_WIDTH;
    localparam int READY_FALL = DEPTH - H2D_READY_MARGIN; // host stops at 504
    localparam int BUSY_RISE  = DEPTH - D2H_BUSY_MARGIN;  // link throttled at 448
    localparam int MAX_CYCLES = 4000;                     // tests take about 1700

    logic clk, rst;
    logic [31:0] h2d_data, d2h_data, ll_tx_data, ll_rx_data;
    fis_mask_t   h2d_mask, d2h_mask, ll_tx_mask, ll_rx_mask;
    h2d_type_t   h2d_type;
    d2h_type_t   d2h_type;
    logic h2d_valid, h2d_ready, d2h_valid, d2h_many, d2h_ready;
    logic ll_tx_last, ll_tx_valid, ll_tx_strobe, ll_frame_req, ll_frame_busy;
    logic ll_rx_valid, ll_incom_start, ll_incom_done, ll_incom_invalidate, ll_rx_busy;

    integer seed;
    int errors, checks, cycles, req_count;
    logic link_pop_en; // lets the link model pop the h2d side
    h2d_entry_t h2d_sent[$], h2d_popped[$];
    d2h_entry_t d2h_exp[$], d2h_got[$];

    sata_fis_buffers u_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin // watchdog
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    always @(negedge clk)
        if (!rst && ll_frame_req)
            req_count = req_count + 1; // counts request pulses

    // link model takes the presented word and strobes it off at the next edge
    always @(posedge clk) begin : link_model
        logic armed; // enable as it stood at the edge
        armed = link_pop_en;
        #2;
        if (armed && ll_tx_valid) begin
            ll_tx_strobe = 1'b1;
            h2d_popped.push_back('{kind: (ll_tx_last ? FIS_LAST : FIS_DATA),
                                   mask: ll_tx_mask, data: ll_tx_data});
        end else begin
            ll_tx_strobe = 1'b0;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2; // drive point
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_h2d_entry(input string name, input h2d_entry_t exp,
                                   input h2d_entry_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %s/%b/%h got %s/%b/%h", $time, name,
                     exp.kind.name(), exp.mask, exp.data, act.kind.name(), act.mask, act.data);
        end
    endtask

    task automatic check_d2h_entry(input string name, input d2h_entry_t exp,
                                   input d2h_entry_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %s/%b/%h got %s/%b/%h", $time, name,
                     exp.kind.name(), exp.mask, exp.data, act.kind.name(), act.mask, act.data);
        end
    endtask

    task automatic write_h2d(input h2d_type_t wkind);
        h2d_valid = 1'b1;
        h2d_type  = wkind;
        h2d_data  = $random(seed);
        h2d_mask  = fis_mask_t'($random(seed));
        h2d_sent.push_back('{kind: wkind, mask: h2d_mask, data: h2d_data});
        next_cycle();
        h2d_valid = 1'b0;
    endtask

    task automatic drain_h2d();
        int idle;
        idle = 0;
        link_pop_en = 1'b1;
        while (idle < 4) begin // pop until the tx side stays empty
            next_cycle();
            idle = ll_tx_valid ? 0 : idle + 1;
        end
        link_pop_en = 1'b0;
    endtask

    task automatic compare_h2d_stream(input string what);
        h2d_entry_t exp;
        int i;
        check_count({what, " popped words"}, h2d_sent.size(), h2d_popped.size());
        for (i = 0; i < h2d_sent.size() && i < h2d_popped.size(); i++) begin
            exp = h2d_sent[i];
            exp.kind = (exp.kind == FIS_LAST) ? FIS_LAST : FIS_DATA; // tx side shows last only
            check_h2d_entry($sformatf("%s ll_tx word %0d", what, i), exp, h2d_popped[i]);
        end
        h2d_sent.delete();
        h2d_popped.delete();
    endtask

    task automatic wait_req(input int target);
        while (req_count < target)
            next_cycle();
        repeat (5) next_cycle(); // room for a stray second pulse
    endtask

    task automatic pulse_incom(input logic start, input logic done, input logic bad);
        ll_incom_start      = start;
        ll_incom_done       = done;
        ll_incom_invalidate = bad;
        next_cycle();
        {ll_incom_start, ll_incom_done, ll_incom_invalidate} = 3'b000;
        if (done || bad) // status word with empty payload
            d2h_exp.push_back('{kind: (bad ? D2H_ERR : D2H_OK), mask: 2'b00, data: 32'h0});
    endtask

    task automatic send_rx_word(input d2h_type_t exp_kind);
        ll_rx_valid = 1'b1;
        ll_rx_data  = $random(seed);
        ll_rx_mask  = fis_mask_t'($random(seed));
        d2h_exp.push_back('{kind: exp_kind, mask: ll_rx_mask, data: ll_rx_data});
        next_cycle();
        ll_rx_valid = 1'b0;
    endtask

    task automatic read_d2h();
        int idle;
        idle = 0;
        d2h_ready = 1'b1;
        while (idle < 4) begin // read until the host side stays empty
            if (d2h_valid) begin
                d2h_got.push_back('{kind: d2h_type, mask: d2h_mask, data: d2h_data});
                idle = 0;
            end else begin
                idle++;
            end
            next_cycle(); // popped on this edge when valid
        end
        d2h_ready = 1'b0;
    endtask

    task automatic compare_d2h_stream(input string what);
        int i;
        check_count({what, " read words"}, d2h_exp.size(), d2h_got.size());
        for (i = 0; i < d2h_exp.size() && i < d2h_got.size(); i++)
            check_d2h_entry($sformatf("%s d2h word %0d", what, i), d2h_exp[i], d2h_got[i]);
        d2h_exp.delete();
        d2h_got.delete();
    endtask

    task automatic test_reset_values();
        check_bit("ll_frame_req", 1'b0, ll_frame_req);
        check_bit("ll_tx_valid", 1'b0, ll_tx_valid);
        check_bit("d2h_valid", 1'b0, d2h_valid);
        check_bit("d2h_many", 1'b0, d2h_many);
        check_bit("ll_rx_busy", 1'b0, ll_rx_busy);
        check_bit("h2d_ready", 1'b1, h2d_ready);
    endtask

    task automatic test_short_fis();
        int base;
        base = req_count;
        ll_frame_busy = 1'b0;
        write_h2d(FIS_HEAD);
        repeat (3) write_h2d(FIS_DATA);
        write_h2d(FIS_LAST); // whole FIS in so a request follows
        wait_req(base + 1);
        check_count("ll_frame_req pulses short fis", base + 1, req_count);
        drain_h2d();
        compare_h2d_stream("short fis");
    endtask

    task automatic test_long_fis_busy();
        int base;
        base = req_count;
        ll_frame_busy = 1'b1;
        write_h2d(FIS_HEAD);
        repeat (70) write_h2d(FIS_DATA); // past the 64 word start level
        repeat (10) next_cycle();
        check_count("ll_frame_req pulses while busy", base, req_count);
        ll_frame_busy = 1'b0;
        wait_req(base + 1);
        check_count("ll_frame_req pulses after busy", base + 1, req_count);
        drain_h2d();
        compare_h2d_stream("long fis");
    endtask

    task automatic test_host_backpressure();
        int n;
        n = 0;
        while (h2d_ready && n < DEPTH) begin
            write_h2d(FIS_DATA);
            n++;
        end
        check_count("words written until h2d_ready fell", READY_FALL, n);
        drain_h2d();
        check_bit("h2d_ready after drain", 1'b1, h2d_ready);
        compare_h2d_stream("back-pressure");
    endtask

    task automatic test_good_receive();
        int i;
        d2h_ready = 1'b0;
        pulse_incom(1'b1, 1'b0, 1'b0);
        for (i = 0; i < 10; i++)
            send_rx_word(i == 0 ? D2H_HEAD : D2H_DMA);
        pulse_incom(1'b0, 1'b1, 1'b0);
        repeat (3) next_cycle(); // status word lands
        check_bit("d2h_many", 1'b1, d2h_many);
        read_d2h();
        compare_d2h_stream("good receive");
    endtask

    task automatic test_bad_receive_busy();
        int n;
        pulse_incom(1'b1, 1'b0, 1'b0);
        for (n = 0; n < 5; n++)
            send_rx_word(n == 0 ? D2H_HEAD : D2H_DMA);
        pulse_incom(1'b0, 1'b0, 1'b1);
        read_d2h();
        compare_d2h_stream("bad receive");
        check_bit("ll_rx_busy when empty", 1'b0, ll_rx_busy);
        pulse_incom(1'b1, 1'b0, 1'b0);
        for (n = 1; n <= BUSY_RISE + 4; n++) begin // reader held off
            send_rx_word(n == 1 ? D2H_HEAD : D2H_DMA);
            check_bit($sformatf("ll_rx_busy at fill %0d", n), n >= BUSY_RISE, ll_rx_busy);
        end
        pulse_incom(1'b0, 1'b1, 1'b0);
        d2h_exp.delete();
    endtask

    initial begin
        seed = 18;
        {errors, checks, cycles, req_count} = '0;
        link_pop_en = 1'b0;
        clk = 1'b0;
        rst = 1'b1;
        {h2d_data, h2d_mask, h2d_valid, d2h_ready} = '0;
        h2d_type = FIS_DATA;
        {ll_tx_strobe, ll_frame_busy, ll_rx_data, ll_rx_mask, ll_rx_valid} = '0;
        {ll_incom_start, ll_incom_done, ll_incom_invalidate} = 3'b000;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_values();
        test_short_fis();
        test_long_fis_busy();
        test_host_backpressure();
        test_good_receive();
        test_bad_receive_busy();
        repeat (5) next_cycle();
        $display("run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/sata_fis_pkg.sv
verilog/fifo_fill_ctrl.sv
verilog/fifo_ram.sv
verilog/h2d_xmit_start_fsm.sv
verilog/d2h_fis_tagger.sv
verilog/sata_fis_buffers.sv
tb/tb_sata_fis_buffers.sv

// ==== Makefile ====
# Verilator build and run for the SATA FIS buffers testbench

VERILATOR ?= verilator
TOP       ?= tb_sata_fis_buffers
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
